// File: audio_mix.f
src/audio_pkg.sv
src/mix_src_if.sv
src/audio_attenuate.sv
src/audio_sum.sv
src/audio_compress.sv
src/audio_mix_top.sv
tests/tb_audio_mix.sv

// File: Makefile
TOP := tb_audio_mix

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f audio_mix.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: tests/tb_audio_mix.sv
////////////////////////////////////////////////////////////
// Self-checking testbench for the audio mixing pipeline.
// Drives random and edge samples through audio_mix_top and
// checks every output, and the cycle it arrives in, against
// a model of the mixing, headroom and compressor rules.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_audio_mix;

	localparam int latency = 4;	// sample_valid cycle to audio_valid cycle
	localparam int no_cd   = 100000;	// Search found nothing

	logic                  clk_sys = 1'b0;
	logic                  reset;
	logic                  sample_valid;
	audio_pkg::sample_t    cdda_l;
	audio_pkg::sample_t    cdda_r;
	audio_pkg::sample_t    psg_l;
	audio_pkg::sample_t    psg_r;
	audio_pkg::sample_t    adpcm;
	logic                  cd_boost;
	audio_pkg::comp_mode_t comp_mode;
	audio_pkg::sample_t    audio_l;
	audio_pkg::sample_t    audio_r;
	logic                  audio_valid;

	int                 cyc = 0;
	int                 n_sent = 0;
	int                 n_checked = 0;
	int                 due_q [$];	// Cycle each output is expected in
	audio_pkg::sample_t exp_l_q [$];
	audio_pkg::sample_t exp_r_q [$];
	logic [31:0]        lfsr_state = 32'h2bb4_fba1;

	audio_mix_top UUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sample_valid (sample_valid),
		.cdda_l       (cdda_l),
		.cdda_r       (cdda_r),
		.psg_l        (psg_l),
		.psg_r        (psg_r),
		.adpcm        (adpcm),
		.cd_boost     (cd_boost),
		.comp_mode    (comp_mode),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.audio_valid  (audio_valid)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) cyc <= cyc + 1;

	////////////////////   Random source   ////////////////////

	// One step per bit of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value      = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic audio_pkg::sample_t random_sample();
		return audio_pkg::sample_t'(take_bits(16));
	endfunction

	////////////////////   Reference model   //////////////////

	function automatic int wrap16(input int x);
		int low;
		low = x & 32'h0000_FFFF;
		return (low >= 32768) ? low - 65536 : low;
	endfunction

	function automatic int wrap18(input int x);
		int low;
		low = x & 32'h0003_FFFF;
		return (low >= 131072) ? low - 262144 : low;
	endfunction

	// Floor division by a power of two
	function automatic int shr(input int x, input int n);
		return x >>> n;
	endfunction

	// Level one channel has after summing and headroom scaling
	function automatic int mix_value(input int cd, input int psg, input int adp, input logic boost);
		int psg_a;
		int adp_a;
		int pre;
		int h;
		psg_a = wrap16(shr(psg, 1) + shr(psg, 2) + shr(psg, 4));
		adp_a = wrap16(shr(adp, 1) + shr(adp, 2) + shr(adp, 3));
		pre   = wrap18(cd + (boost ? cd : 0) + psg_a + adp_a);
		h     = boost ? pre : wrap18(pre + shr(pre, 2));
		return shr(h, 2);
	endfunction

	// Soft knee on the magnitude with the sign put back
	function automatic int knee_value(input int m, input audio_pkg::comp_mode_t mode);
		int v;
		int r;
		int knee;
		int gain;
		int fall;
		int base;
		if (mode == audio_pkg::comp_off) begin
			return m;
		end
		knee = (mode == audio_pkg::comp_4x) ? int'(audio_pkg::knee_4x) : int'(audio_pkg::knee_2x);
		gain = (mode == audio_pkg::comp_4x) ? int'(audio_pkg::gain_4x) : int'(audio_pkg::gain_2x);
		fall = (mode == audio_pkg::comp_4x) ? int'(audio_pkg::fall_4x) : int'(audio_pkg::fall_2x);
		base = (mode == audio_pkg::comp_4x) ? int'(audio_pkg::base_4x) : int'(audio_pkg::base_2x);
		v = (m < 0) ? ((-m) & 32'h0000_FFFF) : m;	// -32768 gives 32768
		if (v < knee) begin
			r = (v * gain) & 32'h0000_FFFF;
		end else begin
			r = ((v - knee) / fall + base) & 32'h0000_FFFF;
		end
		if (m < 0) begin
			r = ~(r - 1) & 32'h0000_FFFF;
		end
		return wrap16(r);
	endfunction

	// Expected {left, right} for one set of inputs
	function automatic logic [31:0] expected_pair(
		input audio_pkg::sample_t    cl,
		input audio_pkg::sample_t    cr,
		input audio_pkg::sample_t    pl,
		input audio_pkg::sample_t    pr,
		input audio_pkg::sample_t    adp,
		input logic                  boost,
		input audio_pkg::comp_mode_t mode
	);
		int l;
		int r;
		l = knee_value(mix_value(int'(cl), int'(pl), int'(adp), boost), mode);
		r = knee_value(mix_value(int'(cr), int'(pr), int'(adp), boost), mode);
		return {audio_pkg::sample_t'(l), audio_pkg::sample_t'(r)};
	endfunction

	// CD input that mixes to a given level with the others at zero
	function automatic int find_cd(input int target, input logic boost);
		int found;
		found = no_cd;
		for (int cd = -32768; cd <= 32767; cd++) begin
			if (found == no_cd && mix_value(cd, 0, 0, boost) == target) begin
				found = cd;
			end
		end
		return found;
	endfunction

	////////////////////   Checks   ///////////////////////////

	task automatic stop_with_failure();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		stop_with_failure();
	endtask

	task automatic check_sample(input string name, input audio_pkg::sample_t expected,
		input audio_pkg::sample_t actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_valid(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		if (due_q.size() != 0 && due_q[0] == cyc) begin
			check_valid("audio_valid", 1'b1, audio_valid);
			check_sample("audio_l", exp_l_q[0], audio_l);
			check_sample("audio_r", exp_r_q[0], audio_r);
			void'(due_q.pop_front());
			void'(exp_l_q.pop_front());
			void'(exp_r_q.pop_front());
			n_checked++;
		end else begin
			check_valid("audio_valid", 1'b0, audio_valid);	// No extra pulses
			if (n_checked == 0) begin	// Reset value until the first sample
				check_sample("audio_l", '0, audio_l);
				check_sample("audio_r", '0, audio_r);
			end
		end
	end

	////////////////////   Stimulus   /////////////////////////

	task automatic step_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) step_cycle();
	endtask

	task automatic send_sample(
		input audio_pkg::sample_t cl,
		input audio_pkg::sample_t cr,
		input audio_pkg::sample_t pl,
		input audio_pkg::sample_t pr,
		input audio_pkg::sample_t adp
	);
		logic [31:0] pair;
		pair         = expected_pair(cl, cr, pl, pr, adp, cd_boost, comp_mode);
		cdda_l       = cl;
		cdda_r       = cr;
		psg_l        = pl;
		psg_r        = pr;
		adpcm        = adp;
		sample_valid = 1'b1;
		due_q.push_back(cyc + latency);
		exp_l_q.push_back(pair[31:16]);
		exp_r_q.push_back(pair[15:0]);
		n_sent++;
		step_cycle();
		sample_valid = 1'b0;
	endtask

	task automatic send_random(input int count, input logic with_gaps);
		for (int i = 0; i < count; i++) begin
			send_sample(random_sample(), random_sample(), random_sample(), random_sample(),
				random_sample());
			if (with_gaps) begin
				idle_cycles(int'(take_bits(2)));	// 0 to 3 idle cycles
			end
		end
	endtask

	task automatic send_edges();
		audio_pkg::sample_t vals [5];
		vals = '{16'sh0000, 16'sh0001, 16'shFFFF, 16'sh7FFF, 16'sh8000};
		for (int i = 0; i < 5; i++) begin
			send_sample(vals[i], vals[i], '0, '0, '0);	// CD only
			send_sample(vals[i], vals[i], vals[i], vals[i], vals[i]);
		end
	endtask

	// Mixed levels just below, at and above the knee for both signs
	task automatic send_knee_points(input int knee);
		int targets [6];
		int cd;
		targets = '{knee - 1, knee, knee + 1, 1 - knee, -knee, -knee - 1};
		for (int i = 0; i < 6; i++) begin
			cd = find_cd(targets[i], cd_boost);
			if (cd == no_cd) begin
				$display("No CD input value mixes to level %0d", targets[i]);
				stop_with_failure();
			end
			send_sample(audio_pkg::sample_t'(cd), audio_pkg::sample_t'(cd), '0, '0, '0);
		end
	endtask

	task automatic wait_output(input int limit);
		int n;
		n = 0;
		while (audio_valid !== 1'b1 && n <= limit) begin
			step_cycle();
			n++;
		end
		if (n > limit) begin
			report_timeout("audio_valid never rose after the first sample");
		end
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (due_q.size() != 0 && n <= limit) begin
			step_cycle();
			n++;
		end
		if (n > limit) begin
			report_timeout("the pipeline did not deliver all outstanding samples");
		end
	endtask

	////////////////////   Test sequence   ////////////////////

	initial begin
		reset        = 1'b1;
		sample_valid = 1'b0;
		cdda_l       = '0;
		cdda_r       = '0;
		psg_l        = '0;
		psg_r        = '0;
		adpcm        = '0;
		cd_boost     = 1'b0;
		comp_mode    = audio_pkg::comp_off;
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// Quiet after reset and then one sample
		idle_cycles(10);
		send_sample(16'sd1000, -16'sd2000, 16'sd300, -16'sd400, 16'sd500);
		wait_output(10);
		wait_drain(10);

		send_random(200, 1'b1);	// Plain mix
		wait_drain(16);

		cd_boost = 1'b1;
		send_random(200, 1'b1);
		wait_drain(16);

		// Master boost modes
		cd_boost  = 1'b0;
		comp_mode = audio_pkg::comp_2x;
		send_random(100, 1'b1);
		send_edges();
		wait_drain(16);
		cd_boost = 1'b1;	// Only doubled CD reaches the 2x knee
		send_knee_points(int'(audio_pkg::knee_2x));
		send_edges();
		wait_drain(16);

		cd_boost  = 1'b0;
		comp_mode = audio_pkg::comp_4x;
		send_random(100, 1'b1);
		send_edges();
		send_knee_points(int'(audio_pkg::knee_4x));
		wait_drain(16);

		// Back to back with four in flight
		send_random(64, 1'b0);
		wait_drain(16);
		idle_cycles(4);

		if (n_checked == n_sent && due_q.size() == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("Only %0d of %0d samples came out", n_checked, n_sent);
			stop_with_failure();
		end
	end

endmodule

// File: src/audio_mix_top.sv
////////////////////////////////////////////////////////////
// Top of the audio output path. Four register stages from
// sample_valid to audio_valid, one new sample accepted per
// clock. cd_boost and comp_mode must stay put while samples
// are in flight.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module audio_mix_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  sample_valid,
	input  audio_pkg::sample_t    cdda_l,
	input  audio_pkg::sample_t    cdda_r,
	input  audio_pkg::sample_t    psg_l,
	input  audio_pkg::sample_t    psg_r,
	input  audio_pkg::sample_t    adpcm,
	input  logic                  cd_boost,
	input  audio_pkg::comp_mode_t comp_mode,
	output audio_pkg::sample_t    audio_l,
	output audio_pkg::sample_t    audio_r,
	output logic                  audio_valid
);

	mix_src_if mix_src ();	// Stage 1 to stage 2

	audio_pkg::sample_t sum_l;	// Stage 3 to stage 4
	audio_pkg::sample_t sum_r;
	logic               sum_valid;

	// Stage 1
	audio_attenuate u_attenuate (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sample_valid (sample_valid),
		.cdda_l       (cdda_l),
		.cdda_r       (cdda_r),
		.psg_l        (psg_l),
		.psg_r        (psg_r),
		.adpcm        (adpcm),
		.src          (mix_src)
	);

	// Stages 2 and 3
	audio_sum u_sum (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cd_boost  (cd_boost),
		.src       (mix_src),
		.sum_l     (sum_l),
		.sum_r     (sum_r),
		.sum_valid (sum_valid)
	);

	// Stage 4
	audio_compress u_compress (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.comp_mode   (comp_mode),
		.sum_l       (sum_l),
		.sum_r       (sum_r),
		.sum_valid   (sum_valid),
		.audio_l     (audio_l),
		.audio_r     (audio_r),
		.audio_valid (audio_valid)
	);

endmodule

// File: src/audio_compress.sv
////////////////////////////////////////////////////////////
// Pipeline stage 4, the master boost. A soft-knee curve
// lifts quiet samples by 2x or 4x and flattens loud ones so
// full scale still fits in 16 bits. Off passes samples on.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module audio_compress (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  audio_pkg::comp_mode_t comp_mode,
	input  audio_pkg::sample_t    sum_l,
	input  audio_pkg::sample_t    sum_r,
	input  logic                  sum_valid,
	output audio_pkg::sample_t    audio_l,
	output audio_pkg::sample_t    audio_r,
	output logic                  audio_valid
);

	// Curve on the magnitude, unsigned 16-bit arithmetic
	function automatic logic [15:0] knee_curve(
		input logic [15:0] v,
		input logic [15:0] knee,
		input logic [3:0]  gain,
		input logic [3:0]  fall,
		input logic [15:0] base
	);
		if (v < knee) begin
			return v * gain;
		end
		return ((v - knee) / fall) + base;
	endfunction

	// Magnitude in, sign restored on the way out
	function automatic audio_pkg::sample_t compr(
		input audio_pkg::sample_t    s,
		input audio_pkg::comp_mode_t mode
	);
		logic [15:0] raw;
		logic [15:0] v;
		logic [15:0] r;
		raw = s;
		v   = raw[15] ? (~raw + 16'd1) : raw;	// 0x8000 stays 0x8000
		if (mode == audio_pkg::comp_4x) begin
			r = knee_curve(v, audio_pkg::knee_4x, audio_pkg::gain_4x,
				audio_pkg::fall_4x, audio_pkg::base_4x);
		end else begin
			r = knee_curve(v, audio_pkg::knee_2x, audio_pkg::gain_2x,
				audio_pkg::fall_2x, audio_pkg::base_2x);
		end
		return raw[15] ? ~(r - 16'd1) : r;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l     <= '0;
			audio_r     <= '0;
			audio_valid <= 1'b0;
		end else begin
			audio_valid <= sum_valid;
			if (sum_valid) begin	// Hold last sample between strobes
				if (comp_mode == audio_pkg::comp_off) begin
					audio_l <= sum_l;
					audio_r <= sum_r;
				end else begin
					audio_l <= compr(sum_l, comp_mode);
					audio_r <= compr(sum_r, comp_mode);
				end
			end
		end
	end

	////////////////////   Checks   ///////////////////////////

	// Mode comes from the top level and must be a real setting
	a_mode_legal: assert property (
		@(posedge clk_sys) disable iff (reset)
		sum_valid |-> comp_mode inside {audio_pkg::comp_off, audio_pkg::comp_2x,
			audio_pkg::comp_4x}
	) else $error("comp_mode holds an illegal value while a sample is in stage 4");

endmodule

// File: src/audio_sum.sv
////////////////////////////////////////////////////////////
// Pipeline stages 2 and 3. Adds the sources into 18-bit
// left and right values with optional CD doubling, then
// scales for headroom and keeps the top 16 bits.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module audio_sum (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               cd_boost,
	mix_src_if.sink            src,
	output audio_pkg::sample_t sum_l,
	output audio_pkg::sample_t sum_r,
	output logic               sum_valid
);

	audio_pkg::sum_t pre_l;	// Raw source sum
	audio_pkg::sum_t pre_r;
	logic            pre_valid;

	audio_pkg::sum_t mix_l;	// After headroom scaling
	audio_pkg::sum_t mix_r;

	// Sign extension into the accumulator
	function automatic audio_pkg::sum_t ext(input audio_pkg::sample_t s);
		return audio_pkg::sum_t'(s);
	endfunction

	// Source sum for one channel, wraps at 18 bits
	function automatic audio_pkg::sum_t mix_sum(
		input audio_pkg::sample_t cd,
		input audio_pkg::sample_t psg,
		input audio_pkg::sample_t adp,
		input logic               boost
	);
		audio_pkg::sum_t cd_twice;
		cd_twice = boost ? ext(cd) : '0;
		return ext(cd) + cd_twice + ext(psg) + ext(adp);
	endfunction

	// 5/4 scaling, skipped when CD audio is already doubled
	function automatic audio_pkg::sum_t headroom(
		input audio_pkg::sum_t v,
		input logic            boost
	);
		return boost ? v : v + (v >>> 2);
	endfunction

	////////////////////   Valid pipe   ///////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pre_valid <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			pre_valid <= src.valid;
			sum_valid <= pre_valid;
		end
	end

	////////////////////   Data pipe   ////////////////////////

	// Stage 2, ADPCM is mono and goes to both sides
	always_ff @(posedge clk_sys) begin
		pre_l <= mix_sum(src.cdda_l, src.psg_l, src.adpcm, cd_boost);
		pre_r <= mix_sum(src.cdda_r, src.psg_r, src.adpcm, cd_boost);
	end

	// Stage 3
	always_ff @(posedge clk_sys) begin
		mix_l <= headroom(pre_l, cd_boost);
		mix_r <= headroom(pre_r, cd_boost);
	end

	// Drop the two guard bits
	assign sum_l = mix_l[audio_pkg::sum_w-1 -: audio_pkg::sample_w];
	assign sum_r = mix_r[audio_pkg::sum_w-1 -: audio_pkg::sample_w];

	////////////////////   Checks   ///////////////////////////

	// Every stage 1 sample leaves here two cycles later, no more no less
	a_sum_latency: assert property (
		@(posedge clk_sys) disable iff (reset)
		sum_valid == $past(src.valid, 2)
	) else $error("sum_valid does not follow stage 1 valid by two cycles");

endmodule

// File: src/audio_attenuate.sv
////////////////////////////////////////////////////////////
// Pipeline stage 1. Registers the CD samples as they are and
// scales the PSG and ADPCM samples down by fixed shift-add
// weights before they reach the mixer.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module audio_attenuate (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               sample_valid,
	input  audio_pkg::sample_t cdda_l,
	input  audio_pkg::sample_t cdda_r,
	input  audio_pkg::sample_t psg_l,
	input  audio_pkg::sample_t psg_r,
	input  audio_pkg::sample_t adpcm,
	mix_src_if.source          src
);

	// PSG weight 1/2 + 1/4 + 1/16 = 13/16
	function automatic audio_pkg::sample_t atten_psg(input audio_pkg::sample_t s);
		return (s >>> 1) + (s >>> 2) + (s >>> 4);
	endfunction

	// ADPCM weight 1/2 + 1/4 + 1/8 = 7/8
	function automatic audio_pkg::sample_t atten_adpcm(input audio_pkg::sample_t s);
		return (s >>> 1) + (s >>> 2) + (s >>> 3);
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			src.valid <= 1'b0;
		end else begin
			src.valid <= sample_valid;
		end
	end

	// Payload follows the strobe
	always_ff @(posedge clk_sys) begin
		src.cdda_l <= cdda_l;
		src.cdda_r <= cdda_r;
		src.psg_l  <= atten_psg(psg_l);
		src.psg_r  <= atten_psg(psg_r);
		src.adpcm  <= atten_adpcm(adpcm);
	end

	////////////////////   Checks   ///////////////////////////

	// Downstream stages count on a clean strobe once out of reset
	a_valid_known: assert property (
		@(posedge clk_sys) disable iff (reset)
		!$isunknown(src.valid)
	) else $error("Stage 1 valid is unknown after reset");

endmodule

// File: src/mix_src_if.sv
////////////////////////////////////////////////////////////
// Attenuated source samples passed from the input stage to
// the summing stage. valid is high for one cycle per sample
// and the data fields only mean something in that cycle.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface mix_src_if;

	logic               valid;
	audio_pkg::sample_t cdda_l;	// CD audio, unchanged
	audio_pkg::sample_t cdda_r;
	audio_pkg::sample_t psg_l;	// Tone generator, attenuated
	audio_pkg::sample_t psg_r;
	audio_pkg::sample_t adpcm;	// Mono, attenuated

	// Stage 1 side
	modport source (
		output valid, cdda_l, cdda_r, psg_l, psg_r, adpcm
	);

	// Stage 2 side
	modport sink (
		input valid, cdda_l, cdda_r, psg_l, psg_r, adpcm
	);

endinterface

// File: src/audio_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, sample types and compressor constants for
// the audio mixing pipeline. Every stage refers to these by
// scoped name, so the sample format is changed here alone.
////////////////////////////////////////////////////////////

package audio_pkg;

	////////////////////   Sample format   ////////////////////

	localparam int sample_w = 16;	// One audio sample
	localparam int sum_w    = 18;	// Mixing accumulator, two guard bits

	typedef logic signed [sample_w-1:0] sample_t;
	typedef logic signed [sum_w-1:0]    sum_t;

	////////////////////   Master boost   /////////////////////

	// Compressor mode, value 3 is not a legal setting
	typedef enum logic [1:0] {
		comp_off = 2'd0,
		comp_2x  = 2'd1,
		comp_4x  = 2'd2
	} comp_mode_t;

	// The knee is picked so that the gain line below it and the
	// flattened line above it meet, and full scale input lands
	// just under full scale output:
	//   knee = 32767 * (fall - 1) / (fall * gain - 1) + 1
	//   base = knee * gain

	// 2x mode
	localparam logic [15:0] knee_2x = 16'd14044;
	localparam logic [3:0]  gain_2x = 4'd2;
	localparam logic [3:0]  fall_2x = 4'd4;	// Slope 1/4 above knee
	localparam logic [15:0] base_2x = 16'd28088;

	// 4x mode
	localparam logic [15:0] knee_4x = 16'd7400;
	localparam logic [3:0]  gain_4x = 4'd4;
	localparam logic [3:0]  fall_4x = 4'd8;	// Slope 1/8 above knee
	localparam logic [15:0] base_4x = 16'd29600;

endpackage
